// ==== hdl/ps2_pkg.sv ====
// PS/2 key word layout and special key scan codes, imported by the capture and decode stages
`default_nettype none

package ps2_pkg;

	localparam int SCAN_CODE_W    = 9;
	localparam int PS2_KEY_W      = 11;
	localparam int PS2_TOGGLE_BIT = 10; // Flips on every new key event
	localparam int PS2_PRESS_BIT  = 9;  // 1 on make, 0 on break

	// Bit 8 set marks an E0 extended code
	typedef logic [SCAN_CODE_W-1:0] scan_code_t;

	// Toggle, press, then scan code
	typedef logic [PS2_KEY_W-1:0] ps2_key_t;

	localparam scan_code_t SC_F1     = 9'h005;
	localparam scan_code_t SC_F2     = 9'h006;
	localparam scan_code_t SC_F3     = 9'h004;
	localparam scan_code_t SC_F4     = 9'h00C;
	localparam scan_code_t SC_F10    = 9'h009;
	localparam scan_code_t SC_LSHIFT = 9'h012;
	localparam scan_code_t SC_RSHIFT = 9'h059;
	localparam scan_code_t SC_LCTRL  = 9'h014;
	localparam scan_code_t SC_RCTRL  = 9'h114;
	localparam scan_code_t SC_LALT   = 9'h011;
	localparam scan_code_t SC_RALT   = 9'h111;

endpackage

`default_nettype wire

// ==== hdl/atom_kbd_pkg.sv ====
// Atom key matrix sizes, row and flag types and the decoded key action word
`default_nettype none

package atom_kbd_pkg;

	localparam int KBD_ROWS = 10;
	localparam int KBD_COLS = 6;

	typedef logic [3:0]          row_addr_t;
	typedef logic [KBD_COLS-1:0] key_row_t; // Active low, 0 means pressed
	typedef logic [2:0]          col_idx_t;
	typedef logic [1:0]          turbo_t;

	typedef enum logic [2:0] {
		FN_TURBO  = 3'd0,
		FN_BREAK  = 3'd1,
		FN_REPEAT = 3'd2,
		FN_SHIFT  = 3'd3,
		FN_CTRL   = 3'd4
	} func_code_t;

	typedef struct packed {
		row_addr_t row;
		col_idx_t  col;
	} matrix_pos_t;

	typedef struct packed {
		func_code_t code;
		turbo_t     turbo_val; // Only meaningful for FN_TURBO
		logic [1:0] pad;
	} func_cmd_t;

	// Seven-bit action word, meaning chosen by the event's is_matrix bit
	typedef union packed {
		matrix_pos_t pos;
		func_cmd_t   fn;
	} kbd_action_u;

	localparam logic LAYOUT_ORIG = 1'b0;
	localparam logic LAYOUT_GAME = 1'b1;

endpackage

`default_nettype wire

// ==== hdl/kbd_event_if.sv ====
// Decoded key event strobe passed from the scan code decoder to the matrix stage
`timescale 1ns/1ps
`default_nettype none

interface kbd_event_if import atom_kbd_pkg::*; ();

	logic        valid;     // One cycle per event, no ready
	logic        press;
	logic        is_matrix; // Selects pos or fn view of action
	kbd_action_u action;

	modport source (output valid, output press, output is_matrix, output action);

	modport sink (input valid, input press, input is_matrix, input action);

endinterface

`default_nettype wire

// ==== hdl/ps2_event_capture.sv ====
// Samples the PS/2 key word under clock enable and turns each toggle into a one-cycle event
`timescale 1ns/1ps
`default_nettype none

module ps2_event_capture import ps2_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       clk_en,
	input  ps2_key_t   ps2_key,
	output logic       cap_valid,
	output logic       cap_press,
	output scan_code_t cap_code
);

	logic toggle_q; // Toggle bit seen on the last enabled cycle
	logic toggled;

	assign toggled = clk_en && (ps2_key[PS2_TOGGLE_BIT] != toggle_q);

	always_ff @(posedge clk) begin
		if (reset) begin
			toggle_q  <= 1'b0;
			cap_valid <= 1'b0;
		end else begin
			cap_valid <= toggled;
			if (clk_en)
				toggle_q <= ps2_key[PS2_TOGGLE_BIT];
		end
	end

	always_ff @(posedge clk) begin
		if (toggled) begin
			cap_press <= ps2_key[PS2_PRESS_BIT];
			cap_code  <= ps2_key[SCAN_CODE_W-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/scancode_decoder.sv ====
// Translates captured scan codes into Atom matrix positions or special functions per layout
`timescale 1ns/1ps
`default_nettype none

module scancode_decoder import ps2_pkg::*, atom_kbd_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        layout,
	input  logic        cap_valid,
	input  logic        cap_press,
	input  scan_code_t  cap_code,
	kbd_event_if.source ev
);

	logic        game_layout;
	logic        key_hit;
	logic        fn_hit;
	matrix_pos_t pos;
	func_cmd_t   fn;
	kbd_action_u action_d;

	assign game_layout = (layout == LAYOUT_GAME);

	// Original Atom layout, bit 8 is a don't care on arrows and COPY
	always_comb begin
		key_hit = 1'b1;
		pos     = '0;
		casez (cap_code)
			9'h029: pos = '{4'd9, 3'd0}; // Space
			9'h054: pos = '{4'd8, 3'd0}; // [
			9'h05D: pos = '{4'd7, 3'd0}; // Backslash
			9'h05B: pos = '{4'd6, 3'd0}; // ]
			9'h00D: pos = '{4'd5, 3'd0}; // Up arrow key on TAB
			9'h058: pos = '{4'd4, 3'd0}; // LOCK on CAPS LOCK
			9'b?_0111_0100: pos = '{4'd3, 3'd0}; // RIGHT
			9'b?_0111_0101: pos = '{4'd2, 3'd0}; // UP
			9'h05A: pos = '{4'd6, 3'd1}; // RETURN
			9'b?_0110_1001: pos = '{4'd5, 3'd1}; // COPY on END
			9'h066: pos = '{4'd4, 3'd1}; // DELETE on backspace
			9'h045: pos = '{4'd3, 3'd1}; // 0
			9'h016: pos = '{4'd2, 3'd1}; // 1
			9'h01E: pos = '{4'd1, 3'd1}; // 2
			9'h026: pos = '{4'd0, 3'd1}; // 3
			9'h025: pos = '{4'd9, 3'd2}; // 4
			9'h02E: pos = '{4'd8, 3'd2}; // 5
			9'h036: pos = '{4'd7, 3'd2}; // 6
			9'h03D: pos = '{4'd6, 3'd2}; // 7
			9'h03E: pos = '{4'd5, 3'd2}; // 8
			9'h046: pos = '{4'd4, 3'd2}; // 9
			9'h052: pos = '{4'd3, 3'd2}; // Colon on quote
			9'h04C: pos = '{4'd2, 3'd2}; // ;
			9'h041: pos = '{4'd1, 3'd2}; // ,
			9'h04E: pos = '{4'd0, 3'd2}; // -
			9'h049: pos = '{4'd9, 3'd3}; // .
			9'h04A: pos = '{4'd8, 3'd3}; // /
			9'h055: pos = '{4'd7, 3'd3}; // @ on equals
			9'h01C: pos = '{4'd6, 3'd3}; // A
			9'h032: pos = '{4'd5, 3'd3}; // B
			9'h021: pos = '{4'd4, 3'd3}; // C
			9'h023: pos = '{4'd3, 3'd3}; // D
			9'h024: pos = '{4'd2, 3'd3}; // E
			9'h02B: pos = '{4'd1, 3'd3}; // F
			9'h034: pos = '{4'd0, 3'd3}; // G
			9'h033: pos = '{4'd9, 3'd4}; // H
			9'h043: pos = '{4'd8, 3'd4}; // I
			9'h03B: pos = '{4'd7, 3'd4}; // J
			9'h042: pos = '{4'd6, 3'd4}; // K
			9'h04B: pos = '{4'd5, 3'd4}; // L
			9'h03A: pos = '{4'd4, 3'd4}; // M
			9'h031: pos = '{4'd3, 3'd4}; // N
			9'h044: pos = '{4'd2, 3'd4}; // O
			9'h04D: pos = '{4'd1, 3'd4}; // P
			9'h015: pos = '{4'd0, 3'd4}; // Q
			9'h02D: pos = '{4'd9, 3'd5}; // R
			9'h01B: pos = '{4'd8, 3'd5}; // S
			9'h02C: pos = '{4'd7, 3'd5}; // T
			9'h03C: pos = '{4'd6, 3'd5}; // U
			9'h02A: pos = '{4'd5, 3'd5}; // V
			9'h01D: pos = '{4'd4, 3'd5}; // W
			9'h022: pos = '{4'd3, 3'd5}; // X
			9'h035: pos = '{4'd2, 3'd5}; // Y
			9'h01A: pos = '{4'd1, 3'd5}; // Z
			9'h076: pos = '{4'd0, 3'd5}; // ESCAPE
			default: key_hit = 1'b0;
		endcase
	end

	// Game layout swaps left SHIFT and left CTRL and puts REPEAT on right ALT
	always_comb begin
		fn_hit = 1'b1;
		fn     = '0;
		case (cap_code)
			SC_F1:     fn = '{FN_TURBO, 2'd0, 2'b00};
			SC_F2:     fn = '{FN_TURBO, 2'd1, 2'b00};
			SC_F3:     fn = '{FN_TURBO, 2'd2, 2'b00};
			SC_F4:     fn = '{FN_TURBO, 2'd3, 2'b00};
			SC_F10:    fn.code = FN_BREAK;
			SC_RSHIFT: fn.code = FN_SHIFT;
			SC_RCTRL:  fn.code = FN_CTRL;
			SC_LSHIFT: fn.code = game_layout ? FN_CTRL : FN_SHIFT;
			SC_LCTRL:  fn.code = game_layout ? FN_SHIFT : FN_CTRL;
			SC_LALT: begin
				fn.code = FN_REPEAT;
				fn_hit  = !game_layout;
			end
			SC_RALT: begin
				fn.code = FN_REPEAT;
				fn_hit  = game_layout;
			end
			default: fn_hit = 1'b0;
		endcase
	end

	always_comb begin
		if (key_hit)
			action_d.pos = pos;
		else
			action_d.fn = fn;
	end

	always_ff @(posedge clk) begin
		if (reset)
			ev.valid <= 1'b0;
		else
			ev.valid <= cap_valid && (key_hit || fn_hit); // Unknown codes are dropped
	end

	always_ff @(posedge clk) begin
		if (cap_valid) begin
			ev.press     <= cap_press;
			ev.is_matrix <= key_hit;
			ev.action    <= action_d;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/key_matrix_state.sv ====
// Holds the Atom key matrix, special key flags and turbo, and reads out the addressed row
`timescale 1ns/1ps
`default_nettype none

module key_matrix_state import atom_kbd_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	kbd_event_if.sink   ev,
	input  row_addr_t   row,
	input  logic [15:0] joy1,
	input  logic [15:0] joy2,
	output key_row_t    keyout,
	output logic        shift_out,
	output logic        ctrl_out,
	output logic        repeat_out,
	output logic        break_out,
	output turbo_t      turbo
);

	key_row_t keys [KBD_ROWS];
	key_row_t row_data;

	// Column order top, up, right, down, left, fire
	function automatic key_row_t joy_cols(input logic [15:0] joy);
		return {1'b1, joy[3], joy[0], joy[2], joy[1], joy[4]};
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < KBD_ROWS; r++)
				keys[r] <= '1;
		end else if (ev.valid && ev.is_matrix) begin
			keys[ev.action.pos.row][ev.action.pos.col] <= ~ev.press;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			shift_out  <= 1'b1;
			ctrl_out   <= 1'b1;
			repeat_out <= 1'b1;
			break_out  <= 1'b1;
			turbo      <= '0;
		end else if (ev.valid && !ev.is_matrix) begin
			case (ev.action.fn.code)
				FN_TURBO:  turbo      <= ev.action.fn.turbo_val; // Press bit ignored
				FN_BREAK:  break_out  <= ~ev.press;
				FN_REPEAT: repeat_out <= ~ev.press;
				FN_SHIFT:  shift_out  <= ~ev.press;
				FN_CTRL:   ctrl_out   <= ~ev.press;
				default:   ;
			endcase
		end
	end

	always_comb begin
		row_data = (row < KBD_ROWS) ? keys[row] : '1; // Rows past the matrix read idle
		case (row)
			4'd0:    keyout = row_data & joy_cols(joy1);
			4'd1:    keyout = row_data & joy_cols(joy2);
			default: keyout = row_data;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/atom_keyboard.sv ====
// Top level of the PS/2 to Atom keyboard matrix pipeline, read by the Atom core's row scan
`timescale 1ns/1ps
`default_nettype none

module atom_keyboard import ps2_pkg::*, atom_kbd_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_en,
	input  logic        layout,
	input  ps2_key_t    ps2_key,
	input  row_addr_t   row,
	input  logic [15:0] joy1,
	input  logic [15:0] joy2,
	output key_row_t    keyout,
	output logic        shift_out,
	output logic        ctrl_out,
	output logic        repeat_out,
	output logic        break_out,
	output turbo_t      turbo
);

	logic       cap_valid;
	logic       cap_press;
	scan_code_t cap_code;

	kbd_event_if ev ();

	ps2_event_capture i_ps2_event_capture (
		.clk       (clk),
		.reset     (reset),
		.clk_en    (clk_en),
		.ps2_key   (ps2_key),
		.cap_valid (cap_valid),
		.cap_press (cap_press),
		.cap_code  (cap_code)
	);

	scancode_decoder i_scancode_decoder (
		.clk       (clk),
		.reset     (reset),
		.layout    (layout),
		.cap_valid (cap_valid),
		.cap_press (cap_press),
		.cap_code  (cap_code),
		.ev        (ev.source)
	);

	key_matrix_state i_key_matrix_state (
		.clk        (clk),
		.reset      (reset),
		.ev         (ev.sink),
		.row        (row),
		.joy1       (joy1),
		.joy2       (joy2),
		.keyout     (keyout),
		.shift_out  (shift_out),
		.ctrl_out   (ctrl_out),
		.repeat_out (repeat_out),
		.break_out  (break_out),
		.turbo      (turbo)
	);

endmodule

`default_nettype wire

// ==== sim/atom_keyboard_assert.sv ====
// Concurrent checks on the matrix stage, bound into every key_matrix_state instance
`timescale 1ns/1ps
`default_nettype none

module atom_keyboard_assert import atom_kbd_pkg::*; (
	input logic       clk,
	input logic       reset,
	input logic       ev_valid,
	input logic       ev_is_matrix,
	input row_addr_t  ev_row,
	input turbo_t     turbo,
	input logic [3:0] flags // Shift, ctrl, repeat, break
);

	int assert_errors = 0; // Summed by the testbench at the end

	turbo_after_strobe: assert property (@(posedge clk) disable iff (reset)
		!$stable(turbo) |-> $past(ev_valid))
	else begin
		$error("turbo changed without a decoded event on the cycle before");
		assert_errors++;
	end

	matrix_row_in_range: assert property (@(posedge clk) disable iff (reset)
		(ev_valid && ev_is_matrix) |-> (ev_row < KBD_ROWS))
	else begin
		$error("matrix event addressed a row outside the key matrix");
		assert_errors++;
	end

	flags_idle_after_reset: assert property (@(posedge clk)
		$past(reset) |-> (flags == 4'hF))
	else begin
		$error("special key flags were not all high after reset");
		assert_errors++;
	end

endmodule

bind key_matrix_state atom_keyboard_assert i_atom_keyboard_assert (
	.clk          (clk),
	.reset        (reset),
	.ev_valid     (ev.valid),
	.ev_is_matrix (ev.is_matrix),
	.ev_row       (ev.action.pos.row),
	.turbo        (turbo),
	.flags        ({shift_out, ctrl_out, repeat_out, break_out})
);

`default_nettype wire

// ==== sim/tb_atom_keyboard.sv ====
// Table-driven testbench for the PS/2 to Atom keyboard matrix, run as the simulation top
`timescale 1ns/1ps
`default_nettype none

module tb_atom_keyboard import ps2_pkg::*, atom_kbd_pkg::*; ();

	logic        clk = 1'b0;
	logic        reset;
	logic        clk_en;
	logic        layout;
	ps2_key_t    ps2_key;
	row_addr_t   row;
	logic [15:0] joy1;
	logic [15:0] joy2;
	key_row_t    keyout;
	logic        shift_out;
	logic        ctrl_out;
	logic        repeat_out;
	logic        break_out;
	turbo_t      turbo;

	string       t_name [$];
	logic        t_layout [$];
	bit          t_send [$]; // 0 reads outputs without a key event
	scan_code_t  t_code [$];
	logic        t_press [$];
	row_addr_t   t_row [$];
	logic [15:0] t_joy1 [$];
	logic [15:0] t_joy2 [$];
	key_row_t    t_exp_row [$];
	logic [3:0]  t_exp_flags [$]; // Shift, ctrl, repeat, break
	turbo_t      t_exp_turbo [$];

	int          err_count = 0;
	logic [31:0] rng = 32'h3595c5d6;
	bit          reset_ok;

	atom_keyboard i_atom_keyboard (.*);

	always #20 clk = ~clk;

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Top column unused, up, right, down, left, fire from bits 3, 0, 2, 1, 4
	function automatic key_row_t joy_mask(input logic [15:0] joy);
		key_row_t m;
		m[5] = 1'b1;
		m[4] = joy[3];
		m[3] = joy[0];
		m[2] = joy[2];
		m[1] = joy[1];
		m[0] = joy[4];
		return m;
	endfunction

	task automatic add_test(input string name, input logic lay, input bit send,
		input scan_code_t code, input logic press, input row_addr_t r,
		input logic [15:0] j1, input logic [15:0] j2, input key_row_t exp_row,
		input logic [3:0] exp_flags, input turbo_t exp_turbo);
		t_name.push_back(name);
		t_layout.push_back(lay);
		t_send.push_back(send);
		t_code.push_back(code);
		t_press.push_back(press);
		t_row.push_back(r);
		t_joy1.push_back(j1);
		t_joy2.push_back(j2);
		t_exp_row.push_back(exp_row);
		t_exp_flags.push_back(exp_flags);
		t_exp_turbo.push_back(exp_turbo);
	endtask

	task automatic key_event(input string name, input logic lay, input scan_code_t code,
		input logic press, input row_addr_t r, input key_row_t exp_row,
		input logic [3:0] exp_flags, input turbo_t exp_turbo);
		add_test(name, lay, 1'b1, code, press, r, 16'hFFFF, 16'hFFFF, exp_row, exp_flags,
			exp_turbo);
	endtask

	// Idle flags and turbo 0 expected
	task automatic read_row(input string name, input row_addr_t r, input logic [15:0] j1,
		input logic [15:0] j2, input key_row_t exp_row);
		add_test(name, LAYOUT_ORIG, 1'b0, '0, 1'b0, r, j1, j2, exp_row, 4'hF, 2'd0);
	endtask

	task automatic build_table();
		logic [15:0] j1;
		logic [15:0] j2;
		for (int r = 0; r < KBD_ROWS; r++)
			read_row($sformatf("reset_row%0d", r), row_addr_t'(r), 16'hFFFF, 16'hFFFF, 6'h3F);
		key_event("a_press", LAYOUT_ORIG, 9'h01C, 1'b1, 4'd6, 6'h37, 4'hF, 2'd0);
		key_event("a_release", LAYOUT_ORIG, 9'h01C, 1'b0, 4'd6, 6'h3F, 4'hF, 2'd0);
		key_event("right_ext_press", LAYOUT_ORIG, 9'h174, 1'b1, 4'd3, 6'h3E, 4'hF, 2'd0);
		key_event("right_ext_release", LAYOUT_ORIG, 9'h174, 1'b0, 4'd3, 6'h3F, 4'hF, 2'd0);
		key_event("right_press", LAYOUT_ORIG, 9'h074, 1'b1, 4'd3, 6'h3E, 4'hF, 2'd0);
		key_event("right_release", LAYOUT_ORIG, 9'h074, 1'b0, 4'd3, 6'h3F, 4'hF, 2'd0);
		key_event("f4_turbo3", LAYOUT_ORIG, SC_F4, 1'b1, 4'd9, 6'h3F, 4'hF, 2'd3);
		key_event("f2_turbo1", LAYOUT_ORIG, SC_F2, 1'b1, 4'd9, 6'h3F, 4'hF, 2'd1);
		key_event("f3_release_turbo2", LAYOUT_ORIG, SC_F3, 1'b0, 4'd9, 6'h3F, 4'hF, 2'd2);
		key_event("f1_turbo0", LAYOUT_ORIG, SC_F1, 1'b1, 4'd9, 6'h3F, 4'hF, 2'd0);
		key_event("f10_press", LAYOUT_ORIG, SC_F10, 1'b1, 4'd9, 6'h3F, 4'b1110, 2'd0);
		key_event("f10_release", LAYOUT_ORIG, SC_F10, 1'b0, 4'd9, 6'h3F, 4'hF, 2'd0);
		key_event("orig_lshift_press", LAYOUT_ORIG, SC_LSHIFT, 1'b1, 4'd9, 6'h3F, 4'b0111, 2'd0);
		key_event("orig_lshift_release", LAYOUT_ORIG, SC_LSHIFT, 1'b0, 4'd9, 6'h3F, 4'hF, 2'd0);
		key_event("orig_lctrl_press", LAYOUT_ORIG, SC_LCTRL, 1'b1, 4'd9, 6'h3F, 4'b1011, 2'd0);
		key_event("orig_lctrl_release", LAYOUT_ORIG, SC_LCTRL, 1'b0, 4'd9, 6'h3F, 4'hF, 2'd0);
		key_event("orig_lalt_press", LAYOUT_ORIG, SC_LALT, 1'b1, 4'd9, 6'h3F, 4'b1101, 2'd0);
		key_event("orig_lalt_release", LAYOUT_ORIG, SC_LALT, 1'b0, 4'd9, 6'h3F, 4'hF, 2'd0);
		key_event("orig_ralt_ignored", LAYOUT_ORIG, SC_RALT, 1'b1, 4'd9, 6'h3F, 4'hF, 2'd0);
		key_event("game_lshift_press", LAYOUT_GAME, SC_LSHIFT, 1'b1, 4'd9, 6'h3F, 4'b1011, 2'd0);
		key_event("game_lshift_release", LAYOUT_GAME, SC_LSHIFT, 1'b0, 4'd9, 6'h3F, 4'hF, 2'd0);
		key_event("game_lctrl_press", LAYOUT_GAME, SC_LCTRL, 1'b1, 4'd9, 6'h3F, 4'b0111, 2'd0);
		key_event("game_lctrl_release", LAYOUT_GAME, SC_LCTRL, 1'b0, 4'd9, 6'h3F, 4'hF, 2'd0);
		key_event("game_ralt_press", LAYOUT_GAME, SC_RALT, 1'b1, 4'd9, 6'h3F, 4'b1101, 2'd0);
		key_event("game_ralt_release", LAYOUT_GAME, SC_RALT, 1'b0, 4'd9, 6'h3F, 4'hF, 2'd0);
		key_event("game_lalt_ignored", LAYOUT_GAME, SC_LALT, 1'b1, 4'd9, 6'h3F, 4'hF, 2'd0);
		key_event("g_press", LAYOUT_ORIG, 9'h034, 1'b1, 4'd0, 6'h37, 4'hF, 2'd0); // Row 0 col 3
		for (int i = 0; i < 4; i++) begin
			rng = xorshift32(rng);
			j1  = rng[15:0];
			j2  = rng[31:16];
			read_row($sformatf("joy1_row0_%0d", i), 4'd0, j1, j2, 6'h37 & joy_mask(j1));
			read_row($sformatf("joy2_row1_%0d", i), 4'd1, j1, j2, joy_mask(j2));
		end
		key_event("g_release", LAYOUT_ORIG, 9'h034, 1'b0, 4'd0, 6'h3F, 4'hF, 2'd0);
		key_event("f3_turbo2", LAYOUT_ORIG, SC_F3, 1'b1, 4'd6, 6'h3F, 4'hF, 2'd2);
		key_event("unmapped_press", LAYOUT_ORIG, 9'h07E, 1'b1, 4'd6, 6'h3F, 4'hF, 2'd2);
		key_event("f1_turbo0_again", LAYOUT_ORIG, SC_F1, 1'b1, 4'd6, 6'h3F, 4'hF, 2'd0);
		for (int r = 0; r < KBD_ROWS; r++)
			read_row($sformatf("unmapped_row%0d", r), row_addr_t'(r), 16'hFFFF, 16'hFFFF, 6'h3F);
		read_row("row12_idle", 4'd12, 16'h0000, 16'h0000, 6'h3F);
	endtask

	task automatic check_row(input string name, input key_row_t exp, input key_row_t act);
		if (act !== exp) begin
			err_count++;
			$display("** Error: %s keyout expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input string flag, input logic exp,
		input logic act);
		if (act !== exp) begin
			err_count++;
			$display("** Error: %s %s expected %b actual %b", name, flag, exp, act);
		end
	endtask

	task automatic check_turbo(input string name, input turbo_t exp, input turbo_t act);
		if (act !== exp) begin
			err_count++;
			$display("** Error: %s turbo expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic wait_reset_release(output bit ok);
		int cycles;
		cycles = 0;
		while (reset !== 1'b0 && cycles < 40) begin
			@(posedge clk);
			cycles++;
		end
		ok = (reset === 1'b0);
	endtask

	task automatic apply_entry(input int i);
		int errs_before;
		errs_before = err_count;
		@(posedge clk);
		#2;
		layout = t_layout[i];
		row    = t_row[i];
		joy1   = t_joy1[i];
		joy2   = t_joy2[i];
		if (t_send[i])
			ps2_key = {~ps2_key[PS2_TOGGLE_BIT], t_press[i], t_code[i]};
		repeat (4) @(posedge clk); // Three stages plus one cycle of margin
		#1;
		check_row(t_name[i], t_exp_row[i], keyout);
		check_flag(t_name[i], "shift_out", t_exp_flags[i][3], shift_out);
		check_flag(t_name[i], "ctrl_out", t_exp_flags[i][2], ctrl_out);
		check_flag(t_name[i], "repeat_out", t_exp_flags[i][1], repeat_out);
		check_flag(t_name[i], "break_out", t_exp_flags[i][0], break_out);
		check_turbo(t_name[i], t_exp_turbo[i], turbo);
		if (err_count == errs_before)
			$display("ok   %s", t_name[i]);
		else
			$display("FAIL %s", t_name[i]);
	endtask

	initial begin
		clk_en  = 1'b1;
		layout  = LAYOUT_ORIG;
		ps2_key = '0;
		row     = '0;
		joy1    = 16'hFFFF;
		joy2    = 16'hFFFF;
		build_table();
		wait_reset_release(reset_ok);
		if (!reset_ok)
			$display("Reset was never released, no tests were run");
		else
			for (int i = 0; i < t_name.size(); i++)
				apply_entry(i);
		$display("%0d tests, %0d mismatches, %0d assertion failures", t_name.size(), err_count,
			i_atom_keyboard.i_key_matrix_state.i_atom_keyboard_assert.assert_errors);
		if (reset_ok && err_count == 0 &&
			i_atom_keyboard.i_key_matrix_state.i_atom_keyboard_assert.assert_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/ps2_pkg.sv
hdl/atom_kbd_pkg.sv
hdl/kbd_event_if.sv
hdl/ps2_event_capture.sv
hdl/scancode_decoder.sv
hdl/key_matrix_state.sv
hdl/atom_keyboard.sv
sim/atom_keyboard_assert.sv
sim/tb_atom_keyboard.sv

// ==== Makefile ====
TOP = tb_atom_keyboard

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
